// ==== common/exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// data and address width
`define XLEN 32

// entries in each register file
`define NREGS 32

// iterations of the shift-subtract divider, one quotient bit each
`define DIV_STEPS 32

`endif

// ==== common/exec_pkg.sv ====
`include "exec_defs.svh"

package exec_pkg;

   // integer operations, branch ops return 1 when taken
   typedef enum logic [4:0] {
      alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
      alu_srl, alu_sra, alu_or, alu_and,
      alu_lui_pass,    // result is src2
      alu_mul, alu_mulh, alu_mulhu, alu_mulhsu,
      alu_div, alu_divu, alu_rem, alu_remu,
      alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
   } alu_op_t;

   // single precision operations
   typedef enum logic [3:0] {
      fpu_add, fpu_sub, fpu_mul,
      fpu_sgnj, fpu_sgnjn, fpu_sgnjx,
      fpu_min, fpu_max,
      fpu_eq, fpu_lt, fpu_le,
      fpu_mv_w_x,      // int reg to float reg
      fpu_mv_x_w       // float reg to int reg
   } fpu_op_t;

   typedef enum logic [1:0] {
      div_idle, div_run, div_done
   } div_state_t;

   typedef enum logic [1:0] {
      fs_idle, fs_unpack, fs_compute, fs_pack
   } fpu_state_t;

   // decoded instruction as handed over by the issuer
   typedef struct packed {
      logic [`XLEN-1:0] pc;
      logic [`XLEN-1:0] imm;          // already sign extended
      logic [4:0]       rs1;
      logic [4:0]       rs2;
      logic [4:0]       rd;
      alu_op_t          alu_op;
      fpu_op_t          fpu_op;
      logic             rv32f;        // result comes from the fpu
      logic             src2_imm;
      logic             jal;
      logic             jalr;
      logic             is_cond_jump;
      logic             wr_int;
      logic             wr_float;
   } instr_t;

endpackage

// ==== alu/alu.sv ====
`timescale 1ns/1ps
`include "exec_defs.svh"

module alu (
   input  logic              clk,
   input  logic              rstn,
   input  logic              enabled,
   input  exec_pkg::alu_op_t op,
   input  logic [`XLEN-1:0]  src1,
   input  logic [`XLEN-1:0]  src2,
   output logic              completed,
   output logic [`XLEN-1:0]  result
);
   import exec_pkg::*;

   localparam int CNT_W = $clog2(`DIV_STEPS);

   alu_op_t            op_q;
   logic [`XLEN-1:0]   a_q, b_q;
   div_state_t         div_state;
   logic [CNT_W-1:0]   step_cnt;
   logic               start_div, div_signed, fits;
   logic [`XLEN-1:0]   quo, rem, mag_b, div_res;
   logic [`XLEN:0]     shifted, diff;
   logic [2*`XLEN-1:0] mul_a, mul_b, mul_p;

   function automatic logic [`XLEN-1:0] magnitude(input logic [`XLEN-1:0] v, input logic sgn);
      return (sgn && v[`XLEN-1]) ? -v : v;
   endfunction

   assign start_div  = enabled && (op inside {alu_div, alu_divu, alu_rem, alu_remu});
   assign div_signed = op_q inside {alu_div, alu_rem};
   assign mag_b      = magnitude(b_q, div_signed);

   // one restoring step per cycle
   assign shifted = {rem, quo[`XLEN-1]};
   assign diff    = shifted - {1'b0, mag_b};
   assign fits    = shifted >= {1'b0, mag_b};

   // one 64 bit multiplier covers all four variants
   assign mul_a = {{`XLEN{a_q[`XLEN-1] && op_q != alu_mulhu}}, a_q};
   assign mul_b = {{`XLEN{b_q[`XLEN-1] && op_q == alu_mulh}}, b_q};
   assign mul_p = mul_a * mul_b;

   always_ff @(posedge clk) begin
      if (rstn) begin
         div_state <= div_idle;
         step_cnt  <= '0;
         completed <= 1'b0;
      end else begin
         completed <= (enabled && !start_div) || (div_state == div_done);
         case (div_state)
            div_idle: begin
               if (start_div) begin
                  div_state <= div_run;
                  step_cnt  <= '0;
               end
            end
            div_run: begin
               step_cnt <= step_cnt + 1'b1;
               if (step_cnt == CNT_W'(`DIV_STEPS-1))
                  div_state <= div_done;
            end
            default: div_state <= div_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (enabled) begin
         op_q <= op;
         a_q  <= src1;
         b_q  <= src2;
         quo  <= magnitude(src1, op inside {alu_div, alu_rem});
         rem  <= '0;
      end else if (div_state == div_run) begin
         quo <= {quo[`XLEN-2:0], fits};
         rem <= fits ? diff[`XLEN-1:0] : shifted[`XLEN-1:0];
      end
      if (div_state == div_done) begin
         if (b_q == '0)   // riscv divide by zero rules
            div_res <= (op_q inside {alu_div, alu_divu}) ? '1 : a_q;
         else if (op_q inside {alu_div, alu_divu})
            div_res <= (div_signed && (a_q[`XLEN-1] ^ b_q[`XLEN-1])) ? -quo : quo;
         else
            div_res <= (div_signed && a_q[`XLEN-1]) ? -rem : rem;  // sign of dividend
      end
   end

   always_comb begin
      case (op_q)
         alu_add:      result = a_q + b_q;
         alu_sub:      result = a_q - b_q;
         alu_sll:      result = a_q << b_q[4:0];
         alu_slt:      result = `XLEN'($signed(a_q) < $signed(b_q));
         alu_sltu:     result = `XLEN'(a_q < b_q);
         alu_xor:      result = a_q ^ b_q;
         alu_srl:      result = a_q >> b_q[4:0];
         alu_sra:      result = $signed(a_q) >>> b_q[4:0];
         alu_or:       result = a_q | b_q;
         alu_and:      result = a_q & b_q;
         alu_lui_pass: result = b_q;
         alu_mul:      result = mul_p[`XLEN-1:0];
         alu_mulh, alu_mulhu, alu_mulhsu: result = mul_p[2*`XLEN-1:`XLEN];
         alu_beq:      result = `XLEN'(a_q == b_q);
         alu_bne:      result = `XLEN'(a_q != b_q);
         alu_blt:      result = `XLEN'($signed(a_q) < $signed(b_q));
         alu_bge:      result = `XLEN'($signed(a_q) >= $signed(b_q));
         alu_bltu:     result = `XLEN'(a_q < b_q);
         alu_bgeu:     result = `XLEN'(a_q >= b_q);
         default:      result = div_res;
      endcase
   end

   // no new issue until the divider has handed back its result
   assert property (@(posedge clk) disable iff (rstn) div_state != div_idle |-> !enabled)
      else $error("alu: enabled while divider busy");

endmodule

// ==== fpu/fpu.sv ====
`timescale 1ns/1ps
`include "exec_defs.svh"

module fpu (
   input  logic              clk,
   input  logic              rstn,
   input  logic              enabled,
   input  exec_pkg::fpu_op_t op,
   input  logic [`XLEN-1:0]  int_src,
   input  logic [`XLEN-1:0]  fsrc1,
   input  logic [`XLEN-1:0]  fsrc2,
   output logic              completed,
   output logic [`XLEN-1:0]  result
);
   import exec_pkg::*;

   fpu_state_t        state;
   fpu_op_t           op_q;
   logic [`XLEN-1:0]  a_q, b_q, i_q;
   logic              sa, sb;          // unpacked, denormals flushed
   logic [7:0]        ea, eb;
   logic [23:0]       ma, mb;
   logic              rs;              // unnormalized result
   logic signed [9:0] re;
   logic [47:0]       rm;
   logic              a_big, sticky;
   logic [7:0]        shamt;
   logic [26:0]       big_m, small_m, aligned;
   logic [53:0]       shift_t;
   logic [27:0]       sum;
   logic [5:0]        lead;
   logic [47:0]       norm;
   logic signed [9:0] exp_n;
   logic [`XLEN-1:0]  arith, mag_a, mag_b;
   logic              any_nan, a_lt_b, a_eq_b;

   always_ff @(posedge clk) begin
      if (rstn) begin
         state     <= fs_idle;
         completed <= 1'b0;
      end else begin
         completed <= (state == fs_compute);
         case (state)
            fs_idle:    if (enabled) state <= fs_unpack;
            fs_unpack:  state <= fs_compute;
            fs_compute: state <= fs_pack;
            default:    state <= fs_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (enabled) begin
         op_q <= op;
         a_q  <= fsrc1;
         b_q  <= fsrc2;
         i_q  <= int_src;
      end
      if (state == fs_unpack) begin
         sa <= a_q[31];
         sb <= b_q[31] ^ (op_q == fpu_sub);
         ea <= a_q[30:23];
         eb <= b_q[30:23];
         ma <= (a_q[30:23] == 8'd0) ? 24'd0 : {1'b1, a_q[22:0]};
         mb <= (b_q[30:23] == 8'd0) ? 24'd0 : {1'b1, b_q[22:0]};
      end
      if (state == fs_compute) begin
         if (op_q == fpu_mul) begin
            rs <= sa ^ sb;
            re <= $signed({2'b0, ea}) + $signed({2'b0, eb}) - 10'sd127;
            rm <= ma * mb;     // hidden bit lands on 46
         end else begin
            rs <= (sum == '0) ? (sa & sb) : (a_big ? sa : sb);
            re <= {2'b0, (a_big ? ea : eb)};
            rm <= {sum, 20'd0};
         end
      end
   end

   // align smaller operand, keep guard, round and sticky
   always_comb begin
      a_big   = {ea, ma} >= {eb, mb};
      shamt   = a_big ? ea - eb : eb - ea;
      big_m   = a_big ? {ma, 3'b0} : {mb, 3'b0};
      small_m = a_big ? {mb, 3'b0} : {ma, 3'b0};
      shift_t = {small_m, 27'd0} >> shamt;
      sticky  = (shamt > 8'd26) ? (small_m != '0) : (shift_t[26:0] != '0);
      aligned = shift_t[53:27] | {26'd0, sticky};
      sum     = (sa != sb) ? {1'b0, big_m} - {1'b0, aligned} : {1'b0, big_m} + {1'b0, aligned};
   end

   // normalize and truncate
   always_comb begin
      lead = 6'd0;
      for (int i = 0; i < 48; i++)
         if (rm[i]) lead = 6'(i);
      norm  = rm << (6'd47 - lead);
      exp_n = re + $signed({4'b0, lead}) - 10'sd46;
      if (rm == '0 || exp_n <= 10'sd0)
         arith = {rs, 31'd0};
      else if (exp_n >= 10'sd255)
         arith = {rs, 8'hff, 23'd0};    // overflow to inf
      else
         arith = {rs, exp_n[7:0], norm[46:24]};
   end

   always_comb begin
      mag_a   = (a_q[30:23] == 8'd0) ? '0 : {1'b0, a_q[30:0]};
      mag_b   = (b_q[30:23] == 8'd0) ? '0 : {1'b0, b_q[30:0]};
      any_nan = (a_q[30:23] == 8'hff && a_q[22:0] != '0)
                || (b_q[30:23] == 8'hff && b_q[22:0] != '0);
      a_eq_b  = (mag_a == '0 && mag_b == '0) || (a_q[31] == b_q[31] && mag_a == mag_b);
      if (a_q[31] != b_q[31])
         a_lt_b = a_q[31];              // -0 orders below +0
      else if (a_q[31])
         a_lt_b = mag_a > mag_b;
      else
         a_lt_b = mag_a < mag_b;
   end

   always_comb begin
      case (op_q)
         fpu_sgnj:   result = {b_q[31], a_q[30:0]};
         fpu_sgnjn:  result = {~b_q[31], a_q[30:0]};
         fpu_sgnjx:  result = {a_q[31] ^ b_q[31], a_q[30:0]};
         fpu_min:    result = a_lt_b ? a_q : b_q;
         fpu_max:    result = a_lt_b ? b_q : a_q;
         fpu_eq:     result = `XLEN'(a_eq_b && !any_nan);
         fpu_lt:     result = `XLEN'(a_lt_b && !a_eq_b && !any_nan);
         fpu_le:     result = `XLEN'((a_lt_b || a_eq_b) && !any_nan);
         fpu_mv_w_x: result = i_q;
         fpu_mv_x_w: result = a_q;
         default:    result = arith;
      endcase
   end

   assert property (@(posedge clk) disable iff (rstn) enabled |-> state == fs_idle)
      else $error("fpu: enabled while busy");

endmodule

// ==== design/reg_files.sv ====
`timescale 1ns/1ps
`include "exec_defs.svh"

module reg_files (
   input  logic              clk,
   input  logic              rstn,
   input  logic [4:0]        rs1,
   input  logic [4:0]        rs2,
   output logic [`XLEN-1:0]  rs1_val,
   output logic [`XLEN-1:0]  rs2_val,
   output logic [`XLEN-1:0]  frs1_val,
   output logic [`XLEN-1:0]  frs2_val,
   input  logic              we_int,
   input  logic              we_float,
   input  logic [4:0]        wd,
   input  logic [`XLEN-1:0]  wdata
);

   logic [`XLEN-1:0] int_regs [`NREGS];
   logic [`XLEN-1:0] flt_regs [`NREGS];

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < `NREGS; i++) begin
            int_regs[i] <= '0;
            flt_regs[i] <= '0;
         end
      end else begin
         if (we_int && wd != 5'd0)
            int_regs[wd] <= wdata;
         if (we_float)
            flt_regs[wd] <= wdata;
      end
   end

   // x0 is hardwired, f0 is an ordinary register
   assign rs1_val  = (rs1 == 5'd0) ? '0 : int_regs[rs1];
   assign rs2_val  = (rs2 == 5'd0) ? '0 : int_regs[rs2];
   assign frs1_val = flt_regs[rs1];
   assign frs2_val = flt_regs[rs2];

endmodule

// ==== design/execute.sv ====
`timescale 1ns/1ps
`include "exec_defs.svh"

module execute (
   input  logic              clk,
   input  logic              rstn,
   input  logic              enabled,
   input  exec_pkg::instr_t  instr,
   input  logic [`XLEN-1:0]  rs1_val,
   input  logic [`XLEN-1:0]  rs2_val,
   input  logic [`XLEN-1:0]  frs1_val,
   input  logic [`XLEN-1:0]  frs2_val,
   output logic              completed,
   output exec_pkg::instr_t  instr_n,
   output logic [`XLEN-1:0]  result,
   output logic              is_jump_chosen,
   output logic [`XLEN-1:0]  jump_dest
);

   logic              alu_completed, fpu_completed, unit_done, cond_taken;
   logic [`XLEN-1:0]  alu_src2, alu_result, fpu_result;
   logic [`XLEN-1:0]  rs1_q, jalr_sum, target;

   assign alu_src2 = instr.src2_imm ? instr.imm : rs2_val;

   alu u_alu (
      .clk       (clk),
      .rstn      (rstn),
      .enabled   (enabled),
      .op        (instr.alu_op),
      .src1      (rs1_val),
      .src2      (alu_src2),
      .completed (alu_completed),
      .result    (alu_result)
   );

   fpu u_fpu (
      .clk       (clk),
      .rstn      (rstn),
      .enabled   (enabled),
      .op        (instr.fpu_op),
      .int_src   (rs1_val),
      .fsrc1     (frs1_val),
      .fsrc2     (frs2_val),
      .completed (fpu_completed),
      .result    (fpu_result)
   );

   assign unit_done  = instr_n.rv32f ? fpu_completed : alu_completed;
   assign cond_taken = instr_n.is_cond_jump && alu_result == `XLEN'(1);
   assign jalr_sum   = rs1_q + instr_n.imm;

   always_comb begin
      if (instr_n.jalr)
         target = {jalr_sum[`XLEN-1:1], 1'b0};
      else if (instr_n.jal || cond_taken)
         target = instr_n.pc + instr_n.imm;
      else
         target = '0;
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         completed      <= 1'b0;
         is_jump_chosen <= 1'b0;
      end else begin
         completed <= unit_done;     // one cycle behind the unit
         if (unit_done)
            is_jump_chosen <= instr_n.jal || instr_n.jalr || cond_taken;
      end
   end

   always_ff @(posedge clk) begin
      if (enabled) begin
         instr_n <= instr;
         rs1_q   <= rs1_val;  // jalr base
      end
      if (unit_done) begin
         result    <= instr_n.rv32f ? fpu_result : alu_result;
         jump_dest <= target;
      end
   end

endmodule

// ==== design/exec_top.sv ====
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_top (
   input  logic              clk,
   input  logic              rstn,
   input  logic              enabled,
   input  exec_pkg::instr_t  instr,
   output logic              completed,
   output logic [`XLEN-1:0]  result,
   output logic              is_jump_chosen,
   output logic [`XLEN-1:0]  jump_dest
);
   import exec_pkg::*;

   instr_t            instr_n;
   logic [`XLEN-1:0]  rs1_val, rs2_val, frs1_val, frs2_val;
   logic              we_int, we_float;
   logic [`XLEN-1:0]  wb_data;

   // write back on the completion pulse
   assign we_int   = completed && instr_n.wr_int && instr_n.rd != 5'd0;
   assign we_float = completed && instr_n.wr_float;
   assign wb_data  = (instr_n.jal || instr_n.jalr) ? instr_n.pc + `XLEN'(4) : result;  // link

   reg_files u_reg_files (
      .clk      (clk),
      .rstn     (rstn),
      .rs1      (instr.rs1),
      .rs2      (instr.rs2),
      .rs1_val  (rs1_val),
      .rs2_val  (rs2_val),
      .frs1_val (frs1_val),
      .frs2_val (frs2_val),
      .we_int   (we_int),
      .we_float (we_float),
      .wd       (instr_n.rd),
      .wdata    (wb_data)
   );

   execute u_execute (
      .clk            (clk),
      .rstn           (rstn),
      .enabled        (enabled),
      .instr          (instr),
      .rs1_val        (rs1_val),
      .rs2_val        (rs2_val),
      .frs1_val       (frs1_val),
      .frs2_val       (frs2_val),
      .completed      (completed),
      .instr_n        (instr_n),
      .result         (result),
      .is_jump_chosen (is_jump_chosen),
      .jump_dest      (jump_dest)
   );

endmodule

// ==== tests/tb_exec_top.sv ====
`timescale 1ns/1ps
`include "exec_defs.svh"

module tb_exec_top;
   import exec_pkg::*;

   typedef struct {
      instr_t           ins;
      logic [`XLEN-1:0] res;
      logic             jmp;
      logic [`XLEN-1:0] dest;
   } row_t;

   localparam logic [`XLEN-1:0] min_int = 32'h8000_0000;
   localparam logic [`XLEN-1:0] neg_one = 32'hffff_ffff;
   localparam logic [`XLEN-1:0] neg_20  = 32'hffff_ffec;
   localparam logic [`XLEN-1:0] f_1p5   = 32'h3fc0_0000;
   localparam logic [`XLEN-1:0] f_2p25  = 32'h4010_0000;
   localparam logic [`XLEN-1:0] f_m3    = 32'hc040_0000;

   logic              clk, rstn, enabled;
   instr_t            instr;
   logic              completed, is_jump_chosen;
   logic [`XLEN-1:0]  result, jump_dest;
   row_t              rows [$];
   integer            seed;
   logic [`XLEN-1:0]  ra, rb;
   int                lat;

   exec_top u_exec_top (
      .clk            (clk),
      .rstn           (rstn),
      .enabled        (enabled),
      .instr          (instr),
      .completed      (completed),
      .result         (result),
      .is_jump_chosen (is_jump_chosen),
      .jump_dest      (jump_dest)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic instr_t reg_instr(alu_op_t op, int rd, int rs1, int rs2);
      instr_t i;
      i        = '0;
      i.alu_op = op;
      i.rd     = 5'(rd);
      i.rs1    = 5'(rs1);
      i.rs2    = 5'(rs2);
      i.wr_int = 1'b1;
      return i;
   endfunction

   function automatic instr_t imm_instr(alu_op_t op, int rd, int rs1, logic [`XLEN-1:0] imm);
      instr_t i;
      i          = reg_instr(op, rd, rs1, 0);
      i.src2_imm = 1'b1;
      i.imm      = imm;
      return i;
   endfunction

   function automatic instr_t branch_instr(alu_op_t op, int rs1, int rs2,
                                           logic [`XLEN-1:0] pc, logic [`XLEN-1:0] imm);
      instr_t i;
      i              = reg_instr(op, 0, rs1, rs2);
      i.wr_int       = 1'b0;
      i.is_cond_jump = 1'b1;
      i.pc           = pc;
      i.imm          = imm;
      return i;
   endfunction

   // link target in rd, alu adds rs1 and imm
   function automatic instr_t jump_instr(logic is_jalr, int rd, int rs1,
                                         logic [`XLEN-1:0] pc, logic [`XLEN-1:0] imm);
      instr_t i;
      i      = imm_instr(alu_add, rd, rs1, imm);
      i.pc   = pc;
      i.jalr = is_jalr;
      i.jal  = !is_jalr;
      return i;
   endfunction

   function automatic instr_t fp_instr(fpu_op_t op, int rd, int rs1, int rs2);
      instr_t i;
      i          = '0;
      i.rv32f    = 1'b1;
      i.fpu_op   = op;
      i.rd       = 5'(rd);
      i.rs1      = 5'(rs1);
      i.rs2      = 5'(rs2);
      i.wr_int   = op inside {fpu_eq, fpu_lt, fpu_le, fpu_mv_x_w};  // int destination
      i.wr_float = !i.wr_int;
      return i;
   endfunction

   // rv32m results, 64 bit math covers the signed overflow case
   function automatic logic [`XLEN-1:0] ref_muldiv(alu_op_t op, logic [`XLEN-1:0] a,
                                                  logic [`XLEN-1:0] b);
      logic signed [63:0] sa, sb;
      logic [63:0]        p;
      sa = $signed(a);
      sb = $signed(b);
      if (b == '0 && op inside {alu_div, alu_divu})
         return '1;
      if (b == '0 && op inside {alu_rem, alu_remu})
         return a;
      case (op)
         alu_mul:    p = sa * sb;
         alu_mulh:   p = (sa * sb) >> 32;
         alu_mulhu:  p = ({32'd0, a} * {32'd0, b}) >> 32;
         alu_mulhsu: p = (sa * $signed({32'd0, b})) >> 32;
         alu_div:    p = sa / sb;
         alu_divu:   p = a / b;
         alu_rem:    p = sa % sb;
         default:    p = a % b;
      endcase
      return p[`XLEN-1:0];
   endfunction

   function automatic int expected_latency(instr_t ins);
      if (ins.rv32f)
         return 4;
      if (ins.alu_op inside {alu_div, alu_divu, alu_rem, alu_remu})
         return `DIV_STEPS + 3;
      return 2;
   endfunction

   task automatic stop_with_failure(string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic compare_word(string name, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   task automatic compare_flag(string name, logic got, logic exp);
      if (got !== exp)
         stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   task automatic push_row(instr_t ins, logic [`XLEN-1:0] res, logic jmp = 1'b0,
                           logic [`XLEN-1:0] dest = '0);
      row_t r;
      r.ins  = ins;
      r.res  = res;
      r.jmp  = jmp;
      r.dest = dest;
      rows.push_back(r);
   endtask

   // one enabled pulse, then count cycles until completed
   task automatic issue_and_wait(instr_t ins, output int cycles);
      repeat (3) @(posedge clk);   // fpu runs on every issue, let it drain
      #1;
      instr   = ins;
      enabled = 1'b1;
      @(posedge clk);
      #1;
      enabled = 1'b0;
      cycles  = 1;
      while (!completed) begin
         if (cycles >= 60)
            stop_with_failure("timeout, completed did not arrive within 60 cycles");
         @(posedge clk);
         #1;
         cycles++;
      end
   endtask

   task automatic build_table();
      alu_op_t md_ops [8];
      md_ops = '{alu_mul, alu_mulh, alu_mulhu, alu_mulhsu,
                 alu_div, alu_divu, alu_rem, alu_remu};
      // registers clear after reset, x0 ignores writes
      push_row(reg_instr(alu_add, 5, 1, 2), 32'd0);
      push_row(imm_instr(alu_add, 0, 0, 32'h123), 32'h123);
      push_row(imm_instr(alu_add, 6, 0, 32'h0), 32'h0);
      ra = $random(seed);
      rb = $random(seed);
      push_row(imm_instr(alu_lui_pass, 1, 0, ra), ra);
      push_row(imm_instr(alu_lui_pass, 2, 0, rb), rb);
      push_row(reg_instr(alu_add, 3, 1, 2), ra + rb);
      push_row(reg_instr(alu_sub, 4, 1, 2), ra - rb);
      push_row(reg_instr(alu_xor, 5, 1, 2), ra ^ rb);
      push_row(reg_instr(alu_or, 5, 1, 2), ra | rb);
      push_row(reg_instr(alu_and, 5, 1, 2), ra & rb);
      push_row(reg_instr(alu_sll, 5, 1, 2), ra << rb[4:0]);
      push_row(reg_instr(alu_srl, 5, 1, 2), ra >> rb[4:0]);
      push_row(reg_instr(alu_sra, 5, 1, 2), $signed(ra) >>> rb[4:0]);
      push_row(reg_instr(alu_slt, 5, 1, 2), `XLEN'($signed(ra) < $signed(rb)));
      push_row(reg_instr(alu_sltu, 5, 1, 2), `XLEN'(ra < rb));
      push_row(imm_instr(alu_add, 7, 1, 32'hffff_fffb), ra - 32'd5);
      push_row(imm_instr(alu_slt, 8, 1, 32'd0), `XLEN'(ra[31]));
      push_row(imm_instr(alu_sltu, 9, 2, neg_one), `XLEN'(rb != neg_one));
      push_row(reg_instr(alu_add, 10, 3, 0), ra + rb);   // x3 read back
      push_row(reg_instr(alu_sub, 10, 0, 4), rb - ra);
      for (int k = 0; k < 8; k++)
         push_row(reg_instr(md_ops[k], 11, 1, 2), ref_muldiv(md_ops[k], ra, rb));
      push_row(imm_instr(alu_lui_pass, 12, 0, min_int), min_int);
      push_row(imm_instr(alu_lui_pass, 13, 0, neg_one), neg_one);
      push_row(imm_instr(alu_lui_pass, 14, 0, 32'd7), 32'd7);
      push_row(imm_instr(alu_lui_pass, 15, 0, neg_20), neg_20);
      for (int k = 4; k < 8; k++) begin
         push_row(reg_instr(md_ops[k], 16, 15, 14), ref_muldiv(md_ops[k], neg_20, 32'd7));
         push_row(reg_instr(md_ops[k], 16, 12, 13), ref_muldiv(md_ops[k], min_int, neg_one));
         push_row(reg_instr(md_ops[k], 16, 15, 0), ref_muldiv(md_ops[k], neg_20, 32'd0));
      end
      push_row(jump_instr(1'b0, 17, 0, 32'h1000, 32'h40), 32'h40, 1'b1, 32'h1040);
      push_row(reg_instr(alu_add, 18, 17, 0), 32'h1004);   // jal link
      push_row(jump_instr(1'b1, 19, 14, 32'h2000, 32'h200), 32'h207, 1'b1, 32'h206);
      push_row(reg_instr(alu_add, 20, 19, 0), 32'h2004);
      push_row(branch_instr(alu_beq, 14, 14, 32'h3000, 32'hffff_fff0), 32'd1, 1'b1, 32'h2ff0);
      push_row(branch_instr(alu_bne, 14, 14, 32'h3000, 32'hffff_fff0), 32'd0);
      push_row(branch_instr(alu_blt, 15, 14, 32'h3000, 32'h80), 32'd1, 1'b1, 32'h3080);
      push_row(branch_instr(alu_bge, 15, 14, 32'h3000, 32'h80), 32'd0);
      push_row(branch_instr(alu_bltu, 15, 14, 32'h3000, 32'h80), 32'd0);
      push_row(branch_instr(alu_bgeu, 15, 14, 32'h3000, 32'h80), 32'd1, 1'b1, 32'h3080);
      // float operands through the int file
      push_row(imm_instr(alu_lui_pass, 21, 0, f_1p5), f_1p5);
      push_row(imm_instr(alu_lui_pass, 22, 0, f_2p25), f_2p25);
      push_row(imm_instr(alu_lui_pass, 23, 0, f_m3), f_m3);
      push_row(fp_instr(fpu_mv_w_x, 1, 21, 0), f_1p5);
      push_row(fp_instr(fpu_mv_w_x, 2, 22, 0), f_2p25);
      push_row(fp_instr(fpu_mv_w_x, 3, 23, 0), f_m3);
      push_row(fp_instr(fpu_add, 4, 1, 2), 32'h4070_0000);   // 3.75
      push_row(fp_instr(fpu_sub, 5, 1, 2), 32'hbf40_0000);   // -0.75
      push_row(fp_instr(fpu_mul, 6, 1, 3), 32'hc090_0000);   // -4.5
      push_row(fp_instr(fpu_mul, 7, 1, 2), 32'h4058_0000);   // 3.375
      push_row(fp_instr(fpu_add, 8, 2, 3), 32'hbf40_0000);
      push_row(fp_instr(fpu_sgnj, 9, 1, 3), 32'hbfc0_0000);
      push_row(fp_instr(fpu_sgnjn, 9, 1, 3), f_1p5);
      push_row(fp_instr(fpu_sgnjx, 9, 3, 3), 32'h4040_0000);
      push_row(fp_instr(fpu_min, 10, 1, 3), f_m3);
      push_row(fp_instr(fpu_max, 10, 1, 3), f_1p5);
      push_row(fp_instr(fpu_eq, 24, 1, 1), 32'd1);
      push_row(fp_instr(fpu_lt, 24, 3, 1), 32'd1);
      push_row(fp_instr(fpu_le, 24, 2, 1), 32'd0);
      push_row(fp_instr(fpu_mv_x_w, 25, 4, 0), 32'h4070_0000);   // f4 read back
      push_row(reg_instr(alu_add, 26, 25, 0), 32'h4070_0000);
   endtask

   initial begin
      seed    = 90;
      rstn    = 1'b1;
      enabled = 1'b0;
      instr   = '0;
      repeat (5) @(posedge clk);
      #1;
      rstn = 1'b0;
      compare_flag("completed", completed, 1'b0);
      compare_flag("is_jump_chosen", is_jump_chosen, 1'b0);
      build_table();
      foreach (rows[n]) begin
         issue_and_wait(rows[n].ins, lat);
         compare_word("latency", lat, expected_latency(rows[n].ins));
         compare_word("result", result, rows[n].res);
         compare_flag("is_jump_chosen", is_jump_chosen, rows[n].jmp);
         compare_word("jump_dest", jump_dest, rows[n].dest);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+common
common/exec_pkg.sv
alu/alu.sv
fpu/fpu.sv
design/reg_files.sv
design/execute.sv
design/exec_top.sv
tests/tb_exec_top.sv

// ==== Bender.yml ====
package:
  name: exec_top

sources:
  - include_dirs:
      - common
    files:
      - common/exec_pkg.sv
      - alu/alu.sv
      - fpu/fpu.sv
      - design/reg_files.sv
      - design/execute.sv
      - design/exec_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_exec_top.sv
